/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f compile.f --top-module pianoTilesTb -Mdir obj_dir
	@out="$$(./obj_dir/VpianoTilesTb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All tests passed"

clean:
	rm -rf obj_dir

/* compile.f */
+incdir+rtl
rtl/tilesPkg.sv
rtl/keyDecoder.sv
rtl/tileSpawner.sv
rtl/tileField.sv
rtl/gameControl.sv
rtl/scoreDigits.sv
rtl/pianoTilesTop.sv
tb/pianoTilesTb.sv

/* rtl/gameControl.sv */
`default_nettype none

module gameControl (
	input wire logic CLOCK_50,
	input wire logic arstN,
	input wire tilesPkg::keyPressT keyPress,
	input wire tilesPkg::fieldEventT fieldEvent,
	output logic playing,
	output logic restart,
	output logic [7:0] score,
	output logic [7:0] highScore
);
	import tilesPkg::*;

	gameStateT state;

	assign playing = (state == PLAYING);

	always_ff @(posedge CLOCK_50 or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= PLAYING;
			restart <= 1'b0;
			score <= 8'd0;
			highScore <= 8'd0;
		end
		else
		begin
			restart <= 1'b0;
			// Trails the score by one cycle
			if (score > highScore)
				highScore <= score;

			case (state)
				PLAYING:
				begin
					if (fieldEvent.hit)
						score <= score + 8'd1;
					if (fieldEvent.miss)
						state <= GAME_OVER;
				end
				GAME_OVER:
				begin
					// Any key starts a new round
					if (keyPress.valid)
					begin
						state <= PLAYING;
						score <= 8'd0;
						restart <= 1'b1;
					end
				end
				default: state <= PLAYING;
			endcase
		end
	end

endmodule

`default_nettype wire

/* rtl/keyDecoder.sv */
`default_nettype none
`include "pianoTiles_params.svh"

module keyDecoder (
	input wire logic CLOCK_50,
	input wire logic arstN,
	input wire logic [7:0] ps2Byte,
	input wire logic ps2Valid,
	output tilesPkg::keyPressT keyPress
);
	import tilesPkg::*;

	scanStateT scanState;
	// One bit per column, set while the key is down
	logic [`NUM_COLUMNS-1:0] held;
	logic codeKnown;
	columnT codeColumn;

	always_comb
	begin
		codeKnown = 1'b1;
		codeColumn = 2'd0;
		case (ps2Byte)
			`SCAN_COL0: codeColumn = 2'd0;
			`SCAN_COL1: codeColumn = 2'd1;
			`SCAN_COL2: codeColumn = 2'd2;
			`SCAN_COL3: codeColumn = 2'd3;
			default: codeKnown = 1'b0;
		endcase
	end

	always_ff @(posedge CLOCK_50 or negedge arstN)
	begin
		if (!arstN)
		begin
			scanState <= MAKE_EXPECTED;
			held <= '0;
			keyPress <= '0;
		end
		else
		begin
			keyPress.valid <= 1'b0;
			if (ps2Valid)
			begin
				if (ps2Byte == `SCAN_BREAK)
					scanState <= BREAK_PENDING;
				else if (scanState == BREAK_PENDING)
				begin
					// Code after F0 is a release, never a press
					scanState <= MAKE_EXPECTED;
					if (codeKnown)
						held[codeColumn] <= 1'b0;
				end
				else if (codeKnown && !held[codeColumn])
				begin
					held[codeColumn] <= 1'b1;
					keyPress.valid <= 1'b1;
					keyPress.column <= codeColumn;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/pianoTilesTop.sv */
`default_nettype none
`include "pianoTiles_params.svh"

module pianoTilesTop #(
	parameter int stepCycles = `STEP_CYCLES_DEFAULT,
	parameter int spawnCycles = `SPAWN_CYCLES_DEFAULT
) (
	input wire logic CLOCK_50,
	input wire logic arstN,
	input wire logic [7:0] ps2Byte,
	input wire logic ps2Valid,
	output tilesPkg::tileSlotsT tiles,
	output logic gameOver,
	output logic [6:0] HEX0,
	output logic [6:0] HEX1,
	output logic [6:0] HEX4,
	output logic [6:0] HEX5
);
	import tilesPkg::*;

	keyPressT keyPress;
	columnT spawnColumn;
	fieldEventT fieldEvent;
	logic spawn;
	logic playing;
	logic restart;
	logic [7:0] score;
	logic [7:0] highScore;

	assign gameOver = ~playing;

	keyDecoder keys (
		.CLOCK_50(CLOCK_50),
		.arstN(arstN),
		.ps2Byte(ps2Byte),
		.ps2Valid(ps2Valid),
		.keyPress(keyPress)
	);

	tileSpawner #(.spawnCycles(spawnCycles)) spawner (
		.CLOCK_50(CLOCK_50),
		.arstN(arstN),
		.playing(playing),
		.restart(restart),
		.spawn(spawn),
		.spawnColumn(spawnColumn)
	);

	tileField #(.stepCycles(stepCycles)) field (
		.CLOCK_50(CLOCK_50),
		.arstN(arstN),
		.playing(playing),
		.restart(restart),
		.spawn(spawn),
		.spawnColumn(spawnColumn),
		.keyPress(keyPress),
		.tiles(tiles),
		.fieldEvent(fieldEvent)
	);

	gameControl control (
		.CLOCK_50(CLOCK_50),
		.arstN(arstN),
		.keyPress(keyPress),
		.fieldEvent(fieldEvent),
		.playing(playing),
		.restart(restart),
		.score(score),
		.highScore(highScore)
	);

	// Score on HEX1:HEX0, best on HEX5:HEX4
	scoreDigits scoreHex (
		.value(score),
		.segOnes(HEX0),
		.segTens(HEX1)
	);

	scoreDigits highHex (
		.value(highScore),
		.segOnes(HEX4),
		.segTens(HEX5)
	);

endmodule

`default_nettype wire

/* rtl/pianoTiles_params.svh */
`ifndef PIANOTILES_PARAMS_SVH
`define PIANOTILES_PARAMS_SVH

// Screen geometry in rows
`define SCREEN_ROWS 120
`define TILE_HEIGHT 30
// Tile is hittable once its bottom row passes this
`define HIT_ROW (`SCREEN_ROWS - `TILE_HEIGHT)
`define NUM_COLUMNS 4

// PS/2 set 2 make codes, columns 0 to 3
`define SCAN_COL0 8'h1C
`define SCAN_COL1 8'h1B
`define SCAN_COL2 8'h23
`define SCAN_COL3 8'h2B
`define SCAN_BREAK 8'hF0

`define LFSR_SEED 24'h800001

// About one screen crossing per second at 50 MHz
`define STEP_CYCLES_DEFAULT 416666
// One new tile per second
`define SPAWN_CYCLES_DEFAULT 50000000

`endif

/* rtl/scoreDigits.sv */
`default_nettype none

module scoreDigits (
	input wire logic [7:0] value,
	output logic [6:0] segOnes,
	output logic [6:0] segTens
);
	logic [7:0] tens;
	logic [3:0] ones;

	// Active low, bit 0 is segment a
	function automatic logic [6:0] encodeDigit(input logic [7:0] digit);
		logic [6:0] seg;
		case (digit)
			8'd0: seg = 7'b1000000;
			8'd1: seg = 7'b1111001;
			8'd2: seg = 7'b0100100;
			8'd3: seg = 7'b0110000;
			8'd4: seg = 7'b0011001;
			8'd5: seg = 7'b0010010;
			8'd6: seg = 7'b0000010;
			8'd7: seg = 7'b1111000;
			8'd8: seg = 7'b0000000;
			8'd9: seg = 7'b0010000;
			// Blank for anything past 9
			default: seg = 7'b1111111;
		endcase
		return seg;
	endfunction

	always_comb
	begin
		tens = value / 8'd10;
		ones = 4'(value % 8'd10);
		segOnes = encodeDigit({4'd0, ones});
		segTens = encodeDigit(tens);
	end

endmodule

`default_nettype wire

/* rtl/tileField.sv */
`default_nettype none
`include "pianoTiles_params.svh"

module tileField #(
	parameter int stepCycles = `STEP_CYCLES_DEFAULT
) (
	input wire logic CLOCK_50,
	input wire logic arstN,
	input wire logic playing,
	input wire logic restart,
	input wire logic spawn,
	input wire tilesPkg::columnT spawnColumn,
	input wire tilesPkg::keyPressT keyPress,
	output tilesPkg::tileSlotsT tiles,
	output tilesPkg::fieldEventT fieldEvent
);
	import tilesPkg::*;

	localparam int stepBits = $clog2(stepCycles + 1);

	logic [stepBits-1:0] stepCount;
	logic stepNow;
	tileSlotsT tilesNext;
	fieldEventT eventNext;
	logic hitFound;
	logic [1:0] hitSlot;
	logic spawnDone;

	assign stepNow = playing && (stepCount == stepBits'(stepCycles - 1));

	always_comb
	begin
		tilesNext = tiles;
		eventNext = '0;
		hitFound = 1'b0;
		hitSlot = 2'd0;
		spawnDone = 1'b0;

		// Press against the current slots, lowest index wins
		if (playing && keyPress.valid)
		begin
			for (int i = 3; i >= 0; i--)
			begin
				if (tiles[i].active && tiles[i].column == keyPress.column
						&& tiles[i].row > `HIT_ROW)
				begin
					hitFound = 1'b1;
					hitSlot = 2'(i);
				end
			end
			if (!hitFound)
				eventNext.miss = 1'b1;
			else if (!tiles[hitSlot].scored)
			begin
				tilesNext[hitSlot].scored = 1'b1;
				eventNext.hit = 1'b1;
			end
		end

		// Fall one row, or drop off the bottom
		if (stepNow)
		begin
			for (int i = 0; i < 4; i++)
			begin
				if (tilesNext[i].active)
				begin
					if (tilesNext[i].row == rowT'(`SCREEN_ROWS - 1))
					begin
						tilesNext[i].active = 1'b0;
						if (!tilesNext[i].scored)
							eventNext.miss = 1'b1;
					end
					else
						tilesNext[i].row = tilesNext[i].row + 1'b1;
				end
			end
		end

		// New tile goes into the first free slot, lost if all are busy
		if (spawn)
		begin
			for (int i = 0; i < 4; i++)
			begin
				if (!spawnDone && !tilesNext[i].active)
				begin
					tilesNext[i] = '{active: 1'b1, scored: 1'b0, column: spawnColumn, row: '0};
					spawnDone = 1'b1;
				end
			end
		end
	end

	always_ff @(posedge CLOCK_50 or negedge arstN)
	begin
		if (!arstN)
		begin
			stepCount <= '0;
			tiles <= '0;
			fieldEvent <= '0;
		end
		else if (restart)
		begin
			stepCount <= '0;
			tiles <= '0;
			fieldEvent <= '0;
		end
		else
		begin
			tiles <= tilesNext;
			fieldEvent <= eventNext;
			if (stepNow)
				stepCount <= '0;
			else if (playing)
				stepCount <= stepCount + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* rtl/tileSpawner.sv */
`default_nettype none
`include "pianoTiles_params.svh"

module tileSpawner #(
	parameter int spawnCycles = `SPAWN_CYCLES_DEFAULT
) (
	input wire logic CLOCK_50,
	input wire logic arstN,
	input wire logic playing,
	input wire logic restart,
	output logic spawn,
	output tilesPkg::columnT spawnColumn
);
	localparam int timerBits = $clog2(spawnCycles + 1);

	logic [timerBits-1:0] timer;
	logic [23:0] lfsr;
	logic [23:0] lfsrNext;

	// Taps 24, 23, 18, 17
	assign lfsrNext = {lfsr[22:0], lfsr[23] ^ lfsr[22] ^ lfsr[17] ^ lfsr[16]};

	// LFSR and spawn update on the same edge
	assign spawnColumn = lfsr[1:0];

	always_ff @(posedge CLOCK_50 or negedge arstN)
	begin
		if (!arstN)
		begin
			timer <= '0;
			lfsr <= `LFSR_SEED;
			spawn <= 1'b0;
		end
		else
		begin
			spawn <= 1'b0;
			if (restart)
				timer <= '0;
			else if (playing)
			begin
				if (timer == timerBits'(spawnCycles - 1))
				begin
					timer <= '0;
					spawn <= 1'b1;
					lfsr <= lfsrNext;
				end
				else
					timer <= timer + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/tilesPkg.sv */
`default_nettype none

package tilesPkg;

	typedef logic [1:0] columnT;
	// Bottom row of a tile
	typedef logic [6:0] rowT;

	typedef struct packed {
		logic valid;
		columnT column;
	} keyPressT;

	typedef struct packed {
		logic active;
		logic scored;
		columnT column;
		rowT row;
	} tileSlotT;

	// Slot 0 has the highest priority
	typedef tileSlotT [3:0] tileSlotsT;

	typedef struct packed {
		logic hit;
		logic miss;
	} fieldEventT;

	typedef enum logic {
		PLAYING,
		GAME_OVER
	} gameStateT;

	typedef enum logic {
		MAKE_EXPECTED,
		BREAK_PENDING
	} scanStateT;

endpackage

`default_nettype wire

/* tb/pianoTilesTb.sv */
`default_nettype none
`include "pianoTiles_params.svh"

module pianoTilesTb;
	timeunit 1ns;
	timeprecision 1ps;
	import tilesPkg::*;

	typedef enum logic [2:0] {
		ACT_IDLE, ACT_SPAWN, ACT_HIT, ACT_REPEAT,
		ACT_BREAK, ACT_WRONG, ACT_RESTART, ACT_FALLOUT
	} actionT;

	typedef struct packed {
		actionT action;
		logic [7:0] score;
		logic [7:0] high;
		logic over;
	} testT;

	localparam int numTests = 12;

	// Action, then score, high score and game-over flag once it settles
	testT tests [numTests] = '{
		'{ACT_IDLE, 8'd0, 8'd0, 1'b0},
		'{ACT_SPAWN, 8'd0, 8'd0, 1'b0},
		'{ACT_SPAWN, 8'd0, 8'd0, 1'b0},
		'{ACT_SPAWN, 8'd0, 8'd0, 1'b0},
		'{ACT_HIT, 8'd1, 8'd1, 1'b0},
		'{ACT_REPEAT, 8'd1, 8'd1, 1'b0},
		'{ACT_BREAK, 8'd1, 8'd1, 1'b0},
		'{ACT_HIT, 8'd2, 8'd2, 1'b0},
		'{ACT_WRONG, 8'd2, 8'd2, 1'b1},
		'{ACT_RESTART, 8'd0, 8'd2, 1'b0},
		'{ACT_HIT, 8'd1, 8'd2, 1'b0},
		'{ACT_FALLOUT, 8'd1, 8'd2, 1'b1}
	};

	// Active low digit patterns with segment a in bit 0
	logic [6:0] segTable [10] = '{
		7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000, 7'b0011001,
		7'b0010010, 7'b0000010, 7'b1111000, 7'b0000000, 7'b0010000
	};

	logic CLOCK_50;
	logic arstN;
	logic [7:0] ps2Byte;
	logic ps2Valid;
	tileSlotsT tiles;
	logic gameOver;
	logic [6:0] HEX0;
	logic [6:0] HEX1;
	logic [6:0] HEX4;
	logic [6:0] HEX5;

	logic [23:0] lfsrModel;
	logic [31:0] randState;
	logic [3:0] held;
	columnT lastColumn;
	actionT currentAction;
	int errors;
	int passed;
	int failed;
	int errorsBefore;

	pianoTilesTop #(.stepCycles(2), .spawnCycles(100)) uut (
		.CLOCK_50(CLOCK_50),
		.arstN(arstN),
		.ps2Byte(ps2Byte),
		.ps2Valid(ps2Valid),
		.tiles(tiles),
		.gameOver(gameOver),
		.HEX0(HEX0),
		.HEX1(HEX1),
		.HEX4(HEX4),
		.HEX5(HEX5)
	);

	initial
	begin
		CLOCK_50 = 1'b0;
		forever
			#20 CLOCK_50 = ~CLOCK_50;
	end

	initial
	begin
		#(numTests * 400 * 40);
		$display("Timeout: the tests did not finish within %0d clock cycles", numTests * 400);
		$display("Some tests failed");
		$finish;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Shift left with new bit 0 from taps 23, 22, 17 and 16
	function automatic logic [23:0] lfsrStep(input logic [23:0] value);
		return {value[22:0], value[23] ^ value[22] ^ value[17] ^ value[16]};
	endfunction

	function automatic logic [7:0] makeCode(input columnT column);
		logic [7:0] code;
		case (column)
			2'd0: code = `SCAN_COL0;
			2'd1: code = `SCAN_COL1;
			2'd2: code = `SCAN_COL2;
			default: code = `SCAN_COL3;
		endcase
		return code;
	endfunction

	// Any active tile of this column below the hit row
	function automatic logic inWindow(input columnT column);
		logic busy;
		busy = 1'b0;
		for (int i = 0; i < 4; i++)
			if (tiles[i].active && tiles[i].column == column && tiles[i].row > `HIT_ROW)
				busy = 1'b1;
		return busy;
	endfunction

	task automatic reportMismatch(input string what, input logic [31:0] actual,
			input logic [31:0] expected);
		$display("ERROR at %0d ns: %s is %0h, expected %0h", $time, what, actual, expected);
		errors++;
	endtask

	task automatic sendByte(input logic [7:0] value);
		@(negedge CLOCK_50);
		ps2Byte = value;
		ps2Valid = 1'b1;
		@(negedge CLOCK_50);
		ps2Valid = 1'b0;
	endtask

	task automatic releaseKey(input columnT column);
		sendByte(`SCAN_BREAK);
		sendByte(makeCode(column));
		held[column] = 1'b0;
	endtask

	// A held key has to come up before it can press again
	task automatic pressKey(input columnT column);
		if (held[column])
			releaseKey(column);
		sendByte(makeCode(column));
		held[column] = 1'b1;
		lastColumn = column;
	endtask

	task automatic settle;
		repeat (8)
			@(negedge CLOCK_50);
	endtask

	task automatic checkSlotsClear;
		for (int i = 0; i < 4; i++)
			if (tiles[i].active)
				reportMismatch($sformatf("slot %0d active", i), 1, 0);
	endtask

	task automatic checkOutputs(input testT test);
		if (HEX0 != segTable[test.score % 10])
			reportMismatch("HEX0", HEX0, segTable[test.score % 10]);
		if (HEX1 != segTable[test.score / 10])
			reportMismatch("HEX1", HEX1, segTable[test.score / 10]);
		if (HEX4 != segTable[test.high % 10])
			reportMismatch("HEX4", HEX4, segTable[test.high % 10]);
		if (HEX5 != segTable[test.high / 10])
			reportMismatch("HEX5", HEX5, segTable[test.high / 10]);
		if (gameOver != test.over)
			reportMismatch("gameOver", gameOver, test.over);
	endtask

	task automatic runTest(input testT test);
		int slot;
		columnT column;
		logic [3:0] wasActive;
		slot = -1;
		case (test.action)
			ACT_IDLE:
				checkSlotsClear();
			ACT_SPAWN:
			begin
				for (int i = 0; i < 4; i++)
					wasActive[i] = tiles[i].active;
				while (slot < 0)
				begin
					@(negedge CLOCK_50);
					for (int i = 3; i >= 0; i--)
						if (tiles[i].active && !wasActive[i])
							slot = i;
					for (int i = 0; i < 4; i++)
						wasActive[i] = tiles[i].active;
				end
				lfsrModel = lfsrStep(lfsrModel);
				if (tiles[slot].column != lfsrModel[1:0])
					reportMismatch("spawn column", tiles[slot].column, lfsrModel[1:0]);
				if (tiles[slot].row != 0)
					reportMismatch("spawn row", tiles[slot].row, 0);
			end
			ACT_HIT:
			begin
				// Lowest unscored slot inside the window
				while (slot < 0)
				begin
					@(negedge CLOCK_50);
					for (int i = 3; i >= 0; i--)
						if (tiles[i].active && !tiles[i].scored && tiles[i].row > `HIT_ROW)
							slot = i;
				end
				pressKey(tiles[slot].column);
				settle();
				if (!tiles[slot].active || !tiles[slot].scored)
					reportMismatch($sformatf("slot %0d scored", slot), tiles[slot].scored, 1);
			end
			ACT_REPEAT:
			begin
				// With the column empty a stray press would end the game
				while (inWindow(lastColumn))
					@(negedge CLOCK_50);
				sendByte(makeCode(lastColumn));
				settle();
			end
			ACT_BREAK:
			begin
				while (inWindow(lastColumn))
					@(negedge CLOCK_50);
				releaseKey(lastColumn);
				// Release a key that is already up so that a decoded press would end the game
				column = lastColumn + 2'd1;
				while (held[column] || inWindow(column))
				begin
					@(negedge CLOCK_50);
					column = column + 2'd1;
				end
				releaseKey(column);
				settle();
			end
			ACT_WRONG:
			begin
				do
				begin
					randState = xorshift(randState);
					column = randState[1:0];
				end while (inWindow(column));
				pressKey(column);
				settle();
			end
			ACT_RESTART:
			begin
				pressKey(2'd0);
				settle();
				checkSlotsClear();
			end
			default:
			begin
				while (!gameOver)
					@(negedge CLOCK_50);
			end
		endcase
		checkOutputs(test);
	endtask

	initial
	begin
		ps2Byte = 8'h00;
		ps2Valid = 1'b0;
		arstN = 1'b0;
		held = '0;
		lastColumn = 2'd0;
		lfsrModel = `LFSR_SEED;
		randState = 32'd62253;
		errors = 0;
		passed = 0;
		failed = 0;
		repeat (8)
			@(negedge CLOCK_50);
		arstN = 1'b1;

		for (int t = 0; t < numTests; t++)
		begin
			errorsBefore = errors;
			currentAction = tests[t].action;
			runTest(tests[t]);
			if (errors == errorsBefore)
			begin
				passed++;
				$display("Test %0d %s passed", t, currentAction.name());
			end
			else
			begin
				failed++;
				$display("Test %0d %s failed", t, currentAction.name());
			end
		end

		$display("Tests run %0d, passed %0d, failed %0d, errors %0d",
			numTests, passed, failed, errors);
		if (failed == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire
